// ==== common/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// boot address of the core
// the iram maps its words relative to this
`define RESET_VECTOR 32'hBFC00000

// instruction memory depth in words
`define IRAM_WORDS 4096

// instruction queue slots
// also the number of credits fetch starts with
`define QUEUE_DEPTH 4

// jr to this address ends the program
`define HALT_TARGET 32'h0

`endif

// ==== common/mips_pkg.sv ====
// shared types for the xori subset core
package mips_pkg;

    // major opcodes decoded by the core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_XORI    = 6'b001110,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // function code of jr inside OP_SPECIAL
    localparam logic [5:0] FUNCT_JR = 6'b001000;

    // i-type view: lw, sw, xori
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // r-type view: jr and the other special ops
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // j-type view, kept for completeness of the word layout
    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } j_fmt_t;

    // one 32-bit instruction word, read in three ways
    // opcode sits in the top six bits for all of them
    typedef union packed {
        i_fmt_t i_fmt;
        r_fmt_t r_fmt;
        j_fmt_t j_fmt;
    } mips_instr_t;

    // fetched word plus the address it came from
    typedef struct packed {
        logic [31:0] pc;
        mips_instr_t instr;
    } fetch_entry_t;

    // data bus request from the execute unit
    // held steady while read or write is high
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] writedata;
        logic        read;
        logic        write;
    } data_req_t;

endpackage

// ==== hdl/xori_2_iram.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module xori_2_iram import mips_pkg::*; (
    // combinational read port, address is a byte address
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    localparam int INDEX_W = $clog2(`IRAM_WORDS);

    logic [31:0] instr_ram [0:`IRAM_WORDS-1];

    // byte offset from the reset vector
    logic [31:0] offset;
    logic [INDEX_W-1:0] word_index;

    // scratch word used while the program is built
    mips_instr_t iw;

    assign offset = instr_address % `RESET_VECTOR;
    // drop the byte bits, keep enough for the array
    assign word_index = offset[INDEX_W+1:2];

    initial begin
        // unused words decode as sll r0 and retire as no-ops
        for (int n = 0; n < `IRAM_WORDS; n++) begin
            instr_ram[n] = '0;
        end

        // words 0..29: lw ri, (i-2)*4(r0)
        for (int r = 2; r < 32; r++) begin
            iw = '0;
            iw.i_fmt.opcode = OP_LW;
            iw.i_fmt.rs = 5'd0;
            iw.i_fmt.rt = 5'(r);
            iw.i_fmt.imm = 16'((r - 2) * 4);
            instr_ram[r - 2] = iw;
        end

        // words 30..59: xori ri, ri, 0xf
        for (int r = 2; r < 32; r++) begin
            iw = '0;
            iw.i_fmt.opcode = OP_XORI;
            iw.i_fmt.rs = 5'(r);
            iw.i_fmt.rt = 5'(r);
            iw.i_fmt.imm = 16'h000F;
            instr_ram[r + 28] = iw;
        end

        // words 60..89: sw ri, 0x100+(i-2)*4(r0)
        for (int r = 2; r < 32; r++) begin
            iw = '0;
            iw.i_fmt.opcode = OP_SW;
            iw.i_fmt.rs = 5'd0;
            iw.i_fmt.rt = 5'(r);
            iw.i_fmt.imm = 16'(16'h0100 + (r - 2) * 4);
            instr_ram[r + 58] = iw;
        end

        // word 90: jr r0, r0 is the halt target
        iw = '0;
        iw.r_fmt.opcode = OP_SPECIAL;
        iw.r_fmt.rs = 5'd0;
        iw.r_fmt.funct = FUNCT_JR;
        instr_ram[90] = iw;
    end

    // read path
    always_comb begin
        instr_readdata = instr_ram[word_index];
    end

endmodule

// ==== fetch/instr_fetch.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module instr_fetch import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // iram read port
    output logic [31:0]  instr_address,
    input  logic [31:0]  instr_readdata,
    // towards the instruction queue
    output logic         push,
    output fetch_entry_t push_entry,
    input  logic         credit_return,
    // end of program from execute
    input  logic         halt
);

    localparam int CREDIT_W = $clog2(`QUEUE_DEPTH + 1);

    logic [31:0] pc;
    // free queue slots as seen from here
    logic [CREDIT_W-1:0] credits;
    // set once the program has ended
    logic halted;

    // iram is read straight from the pc
    assign instr_address = pc;

    // issue whenever a slot is free
    // nothing goes out in the halt cycle, the queue flushes on that edge
    assign push = (credits != '0) && !halted && !halt;

    always_comb begin
        push_entry.pc = pc;
        push_entry.instr = instr_readdata;
    end

    // program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_VECTOR;
        end else if (push) begin
            pc <= pc + 32'd4;
        end
    end

    // credit counter
    // a push spends one, a return gives one back the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(`QUEUE_DEPTH);
        end else if (!halted && !halt) begin
            case ({push, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                // push and return together leave it unchanged
                default: credits <= credits;
            endcase
        end
    end

    // stop for good after halt, credits stay frozen
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt) begin
            halted <= 1'b1;
        end
    end

endmodule

// ==== fetch/instr_queue.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module instr_queue import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // from fetch, never refused since fetch holds a credit
    input  logic         push,
    input  fetch_entry_t push_entry,
    // head towards execute
    output logic         head_valid,
    output fetch_entry_t head_entry,
    input  logic         pop,
    // one pulse per pop back to fetch
    output logic         credit_return,
    // empties the queue on halt
    input  logic         flush
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int COUNT_W = $clog2(`QUEUE_DEPTH + 1);

    fetch_entry_t slots [`QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] count;
    // pop only counts against a valid head
    logic pop_ok;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_entry = slots[rd_ptr];
    assign pop_ok = pop && head_valid;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_entry;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit pulse follows the pop by one edge
    // the pop that causes a flush gives nothing back, fetch has stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_ok && !flush;
        end
    end

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module execute_unit import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // queue head
    input  logic         head_valid,
    input  fetch_entry_t head_entry,
    output logic         pop,
    // data memory bus
    output data_req_t    data_req,
    input  logic [31:0]  data_readdata,
    input  logic         data_waitrequest,
    // program end
    output logic         halt,
    output logic         active
);

    mips_instr_t instr;

    // general purpose registers, r0 is never written
    logic [31:0] regs [32];

    // operands
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] mem_address;

    // decoded class of the head word
    logic is_lw;
    logic is_sw;
    logic is_xori;
    logic is_jr;

    // head present and core still running
    logic issue;

    // register write port
    logic        wr_en;
    logic [4:0]  wr_reg;
    logic [31:0] wr_data;

    assign instr = head_entry.instr;

    // decode through the union
    always_comb begin
        is_lw = 1'b0;
        is_sw = 1'b0;
        is_xori = 1'b0;
        is_jr = 1'b0;
        case (instr.i_fmt.opcode)
            OP_LW: is_lw = 1'b1;
            OP_SW: is_sw = 1'b1;
            OP_XORI: is_xori = 1'b1;
            // only jr is of interest among the special ops
            OP_SPECIAL: is_jr = (instr.r_fmt.funct == FUNCT_JR);
            // anything else retires with no effect
            default: is_lw = 1'b0;
        endcase
    end

    // register reads, r0 reads zero
    assign rs_value = (instr.i_fmt.rs == 5'd0) ? '0 : regs[instr.i_fmt.rs];
    assign rt_value = (instr.i_fmt.rt == 5'd0) ? '0 : regs[instr.i_fmt.rt];

    // immediate forms
    assign imm_sext = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
    assign imm_zext = {16'h0000, instr.i_fmt.imm};
    // lw and sw share the base plus offset address
    assign mem_address = rs_value + imm_sext;

    assign issue = head_valid && active;

    // bus request, stays put while the head is held
    always_comb begin
        data_req.address = mem_address;
        data_req.writedata = rt_value;
        data_req.read = issue && is_lw;
        data_req.write = issue && is_sw;
    end

    // retire: memory ops wait for the bus, the rest go at once
    assign pop = issue && ((is_lw || is_sw) ? !data_waitrequest : 1'b1);

    // jr to the halt target ends the program
    assign halt = pop && is_jr && (rs_value == `HALT_TARGET);

    // write back of lw and xori lands at retirement
    assign wr_en = pop && (is_lw || is_xori) && (instr.i_fmt.rt != 5'd0);
    assign wr_reg = instr.i_fmt.rt;
    assign wr_data = is_lw ? data_readdata : (rs_value ^ imm_zext);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // falls with halt and stays low until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b1;
        end else if (halt) begin
            active <= 1'b0;
        end
    end

endmodule

// ==== hdl/mips_xori_core.sv ====
`timescale 1ns/1ps

module mips_xori_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // data memory bus
    output logic [31:0] data_address,
    output logic [31:0] data_writedata,
    output logic        data_read,
    output logic        data_write,
    input  logic [31:0] data_readdata,
    input  logic        data_waitrequest,
    // low once the program has ended
    output logic        active
);

    // fetch side
    logic [31:0]  instr_address;
    logic [31:0]  instr_readdata;
    logic         push;
    fetch_entry_t push_entry;
    logic         credit_return;

    // execute side
    logic         head_valid;
    fetch_entry_t head_entry;
    logic         pop;
    logic         halt;
    data_req_t    data_req;

    xori_2_iram iram0 (
        .instr_address(instr_address),
        .instr_readdata(instr_readdata)
    );

    instr_fetch fetch0 (
        .clk(clk),
        .reset(reset),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .push(push),
        .push_entry(push_entry),
        .credit_return(credit_return),
        .halt(halt)
    );

    // halt doubles as the queue flush
    instr_queue queue0 (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_entry(push_entry),
        .head_valid(head_valid),
        .head_entry(head_entry),
        .pop(pop),
        .credit_return(credit_return),
        .flush(halt)
    );

    execute_unit exec0 (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .head_entry(head_entry),
        .pop(pop),
        .data_req(data_req),
        .data_readdata(data_readdata),
        .data_waitrequest(data_waitrequest),
        .halt(halt),
        .active(active)
    );

    // bus request out to the pins
    assign data_address = data_req.address;
    assign data_writedata = data_req.writedata;
    assign data_read = data_req.read;
    assign data_write = data_req.write;

endmodule

// ==== tests/mips_xori_tb.sv ====
`timescale 1ns/1ps

module mips_xori_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CASES = 30;
    // 91 instructions at up to 8 cycles each plus reset
    localparam int WATCHDOG_NS = 91 * 8 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_readdata;
    logic        data_waitrequest;
    logic        active;

    // even entries hold load words, odd entries the expected store words
    logic [31:0] case_words [0:2*NUM_CASES-1];

    // completed bus transfers in order of completion
    logic [31:0] read_addr_q [$];
    logic [31:0] write_addr_q [$];
    logic [31:0] write_data_q [$];
    // loads that complete once a store has already gone out
    int reads_after_store;

    // bookkeeping for the report
    int test_errors;
    int tests_passed;
    int tests_failed;
    string test_name;

    mips_xori_core dut0 (
        .clk(clk),
        .reset(reset),
        .data_address(data_address),
        .data_writedata(data_writedata),
        .data_read(data_read),
        .data_write(data_write),
        .data_readdata(data_readdata),
        .data_waitrequest(data_waitrequest),
        .active(active)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // data memory where word k at address 4k holds load word k
    function automatic logic [31:0] load_model(input logic [31:0] address);
        int word_index;
        word_index = int'(address >> 2);
        if (address[1:0] == 2'b00 && word_index < NUM_CASES) begin
            return case_words[2 * word_index];
        end
        // outside the table the word still depends on every address bit
        return ~address ^ 32'h3C3C_3C3C;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: pass", test_name);
            tests_passed++;
        end else begin
            $display("test %s: fail with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // bus inputs move 1 ns after the rising edge
    // roughly one cycle in three is stalled
    initial begin
        void'($urandom(32'haf50a055));
        forever begin
            @(posedge clk);
            #1;
            data_waitrequest = ($urandom % 3) == 0;
            data_readdata = load_model(data_address);
        end
    end

    // mid-cycle view of the bus
    // a transfer completes when wait request is low
    always @(negedge clk) begin
        if (!reset) begin
            if (data_read && !data_waitrequest) begin
                read_addr_q.push_back(data_address);
                if (write_addr_q.size() != 0) begin
                    reads_after_store++;
                end
            end
            if (data_write && !data_waitrequest) begin
                write_addr_q.push_back(data_address);
                write_data_q.push_back(data_writedata);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timed out: the core did not halt within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int stores_at_halt;
        int post_halt_accesses;
        int post_halt_active;
        int rises_bad;
        int n;

        clk = 1'b0;
        reset = 1'b1;
        data_readdata = '0;
        data_waitrequest = 1'b0;
        reads_after_store = 0;
        tests_passed = 0;
        tests_failed = 0;
        post_halt_accesses = 0;
        post_halt_active = 0;
        rises_bad = 0;
        $readmemh("tests/xori_cases.mem", case_words);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // still before the first edge after release
        begin_test("reset_state");
        @(negedge clk);
        check_value("reset_state active", 32'd1, 32'(active));
        check_value("reset_state data_read", 32'd0, 32'(data_read));
        check_value("reset_state data_write", 32'd0, 32'(data_write));
        finish_test();

        // run until the jr retires
        wait (active == 1'b0);
        @(negedge clk);
        stores_at_halt = write_addr_q.size();

        // nothing may reach the bus once the core has stopped
        for (n = 0; n < 20; n++) begin
            @(negedge clk);
            if (data_read || data_write) begin
                post_halt_accesses++;
            end
            if (active) begin
                post_halt_active++;
            end
        end

        begin_test("loads");
        check_value("loads count", 32'(NUM_CASES), 32'(read_addr_q.size()));
        for (n = 0; n < NUM_CASES && n < read_addr_q.size(); n++) begin
            check_value($sformatf("loads[%0d] address", n), 32'(4 * n), read_addr_q[n]);
        end
        finish_test();

        begin_test("stores");
        check_value("stores count", 32'(NUM_CASES), 32'(write_addr_q.size()));
        for (n = 0; n < NUM_CASES; n++) begin
            // file column two must be column one with the low nibble flipped
            check_value($sformatf("cases[%0d] expected", n),
                        case_words[2 * n] ^ 32'h0000_000F, case_words[2 * n + 1]);
        end
        for (n = 0; n < NUM_CASES && n < write_addr_q.size(); n++) begin
            check_value($sformatf("stores[%0d] address", n),
                        32'h100 + 32'(4 * n), write_addr_q[n]);
            check_value($sformatf("stores[%0d] data", n),
                        case_words[2 * n + 1], write_data_q[n]);
        end
        finish_test();

        begin_test("ordering");
        check_value("ordering loads after first store", 32'd0, 32'(reads_after_store));
        for (n = 1; n < write_addr_q.size(); n++) begin
            if (write_addr_q[n] <= write_addr_q[n - 1]) begin
                rises_bad++;
            end
        end
        check_value("ordering store addresses not rising", 32'd0, 32'(rises_bad));
        finish_test();

        begin_test("halt");
        check_value("halt stores before active fell", 32'(NUM_CASES), 32'(stores_at_halt));
        check_value("halt bus accesses afterwards", 32'd0, 32'(post_halt_accesses));
        check_value("halt active cycles afterwards", 32'd0, 32'(post_halt_active));
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/xori_cases.mem ====
// columns: load word at address 4k, expected store word (load word xor 0xf)
00000000 0000000F
FFFFFFFF FFFFFFF0
12345678 12345677
89ABCDEF 89ABCDE0
DEADBEEF DEADBEE0
CAFEF00D CAFEF002
0000000F 00000000
A5A5A5A5 A5A5A5AA
5A5A5A5A 5A5A5A55
00010002 0001000D
7FFFFFFF 7FFFFFF0
80000000 8000000F
13579BDF 13579BD0
2468ACE0 2468ACEF
0F0F0F0F 0F0F0F00
F0F0F0F0 F0F0F0FF
31415926 31415929
27182818 27182817
00C0FFEE 00C0FFE1
FEEDFACE FEEDFAC1
11111111 1111111E
22222222 2222222D
33333333 3333333C
44444444 4444444B
55555555 5555555A
66666666 66666669
77777777 77777778
88888888 88888887
99999999 99999996
ABCDEF01 ABCDEF0E

// ==== project.f ====
+incdir+common
common/mips_pkg.sv
hdl/xori_2_iram.sv
fetch/instr_fetch.sv
fetch/instr_queue.sv
hdl/execute_unit.sv
hdl/mips_xori_core.sv
tests/mips_xori_tb.sv

// ==== Makefile ====
TOP = mips_xori_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
